//--- hw/periph_cfg_pkg.sv
// address map, register offsets and reset values shared by the APB peripheral blocks
package periph_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned OFS_W       = 12;  // byte offset inside one slave window
  localparam int unsigned SLV_SEL_LSB = 12;
  localparam int unsigned SLV_SEL_MSB = 15;

  // slave slots, index taken from paddr[15:12]
  localparam int unsigned SLV_GPIO     = 0;
  localparam int unsigned SLV_SOC_CTRL = 1;
  localparam int unsigned SLV_TIMER    = 2;
  localparam int unsigned N_SLV        = 3;

  localparam int unsigned N_GPIO = 32;

  localparam logic [DATA_W-1:0] BOOTADDR_RST = 32'h1C00_8080;  // boot rom entry
  localparam logic [DATA_W-1:0] INFO_WORD    = 32'h0001_0004;

  ////////////////////////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////////////////////////
  localparam logic [OFS_W-1:0] SOC_INFO_OFS     = 12'h000;
  localparam logic [OFS_W-1:0] SOC_BOOTADDR_OFS = 12'h004;
  localparam logic [OFS_W-1:0] SOC_FETCHEN_OFS  = 12'h008;
  localparam logic [OFS_W-1:0] SOC_SOFTRST_OFS  = 12'h00C;

  localparam logic [OFS_W-1:0] GPIO_DIR_OFS     = 12'h000;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS      = 12'h004;
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS     = 12'h008;
  localparam logic [OFS_W-1:0] GPIO_INTEN_OFS   = 12'h00C;
  localparam logic [OFS_W-1:0] GPIO_INTSTAT_OFS = 12'h010;

  localparam logic [OFS_W-1:0] TMR_CFG_OFS   = 12'h000;
  localparam logic [OFS_W-1:0] TMR_COUNT_OFS = 12'h004;
  localparam logic [OFS_W-1:0] TMR_CMP_OFS   = 12'h008;

  // timer cfg fields
  localparam int unsigned TMR_CFG_EN_BIT  = 0;
  localparam int unsigned TMR_CFG_REF_BIT = 1;
  localparam int unsigned TMR_CFG_CLR_BIT = 2;  // self clearing

endpackage

//--- hw/periph_evt_pkg.sv
// bit positions of the fabric-controller event vector built by the peripheral top level
package periph_evt_pkg;

  localparam int unsigned N_FC_EVT = 32;

  // 0..6 left for sw events, tied low here
  localparam int unsigned EVT_TIMER_LO = 7;   // machine timer slot
  localparam int unsigned EVT_GPIO     = 11;

  // timer irq is mirrored on a second line
  localparam int unsigned EVT_TIMER_IRQ = 16;

  // slow reference clock edges
  localparam int unsigned EVT_REF_RISE = 18;
  localparam int unsigned EVT_REF_FALL = 19;

endpackage

//--- hw/apb_if.sv
// APB bundle between the peripheral decoder and one register slave, master and slave views
`timescale 1ns/1ps

interface apb_if;

  logic [periph_cfg_pkg::ADDR_W-1:0] paddr;
  logic [periph_cfg_pkg::DATA_W-1:0] pwdata;
  logic                              pwrite;
  logic                              psel;
  logic                              penable;
  logic [periph_cfg_pkg::DATA_W-1:0] prdata;
  logic                              pready;
  logic                              pslverr;

  // decoder side
  modport master (
    output paddr, pwdata, pwrite, psel, penable,
    input  prdata, pready, pslverr
  );

  // register block side
  modport slave (
    input  paddr, pwdata, pwrite, psel, penable,
    output prdata, pready, pslverr
  );

endinterface

//--- hw/apb_periph_decoder.sv
// splits the single APB port over the peripheral slaves and returns the addressed response
`timescale 1ns/1ps

module apb_periph_decoder (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [periph_cfg_pkg::ADDR_W-1:0] paddr_i,
  input  logic [periph_cfg_pkg::DATA_W-1:0] pwdata_i,
  input  logic                              pwrite_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  output logic [periph_cfg_pkg::DATA_W-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  apb_if.master                             gpio_bus,
  apb_if.master                             soc_ctrl_bus,
  apb_if.master                             timer_bus
);

  logic [periph_cfg_pkg::SLV_SEL_MSB-periph_cfg_pkg::SLV_SEL_LSB:0] slv_idx;
  logic                                                          slv_hit;

  assign slv_idx = paddr_i[periph_cfg_pkg::SLV_SEL_MSB:periph_cfg_pkg::SLV_SEL_LSB];
  assign slv_hit = slv_idx < periph_cfg_pkg::N_SLV;  // slots 3..15 unmapped

  // request goes to every slave, only psel is steered
  assign gpio_bus.paddr      = paddr_i;
  assign gpio_bus.pwdata     = pwdata_i;
  assign gpio_bus.pwrite     = pwrite_i;
  assign gpio_bus.penable    = penable_i;
  assign gpio_bus.psel       = psel_i && (slv_idx == periph_cfg_pkg::SLV_GPIO);

  assign soc_ctrl_bus.paddr   = paddr_i;
  assign soc_ctrl_bus.pwdata  = pwdata_i;
  assign soc_ctrl_bus.pwrite  = pwrite_i;
  assign soc_ctrl_bus.penable = penable_i;
  assign soc_ctrl_bus.psel    = psel_i && (slv_idx == periph_cfg_pkg::SLV_SOC_CTRL);

  assign timer_bus.paddr     = paddr_i;
  assign timer_bus.pwdata    = pwdata_i;
  assign timer_bus.pwrite    = pwrite_i;
  assign timer_bus.penable   = penable_i;
  assign timer_bus.psel      = psel_i && (slv_idx == periph_cfg_pkg::SLV_TIMER);

  // response mux
  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b1;                  // unmapped slot finishes in the access cycle
    pslverr_o = psel_i && !slv_hit;    // error only on a dead slot
    case (slv_idx)
      periph_cfg_pkg::SLV_GPIO: begin
        prdata_o  = gpio_bus.prdata;
        pready_o  = gpio_bus.pready;
        pslverr_o = gpio_bus.pslverr;
      end
      periph_cfg_pkg::SLV_SOC_CTRL: begin
        prdata_o  = soc_ctrl_bus.prdata;
        pready_o  = soc_ctrl_bus.pready;
        pslverr_o = soc_ctrl_bus.pslverr;
      end
      periph_cfg_pkg::SLV_TIMER: begin
        prdata_o  = timer_bus.prdata;
        pready_o  = timer_bus.pready;
        pslverr_o = timer_bus.pslverr;
      end
      default: ;
    endcase
  end

  // address and direction held from setup into access
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && penable_i) |-> ($stable(paddr_i) && $stable(pwrite_i)));

  // access phase must follow a setup phase
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (psel_i && penable_i) |-> $past(psel_i && !penable_i));

endmodule

//--- hw/soc_ctrl_regs.sv
// SoC control registers: boot address, fetch enable with external override, info, soft reset
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  apb_if.slave                              bus,
  input  logic                              fc_fetch_en_valid_i,
  input  logic                              fc_fetch_en_i,
  output logic [periph_cfg_pkg::DATA_W-1:0] fc_bootaddr_o,
  output logic                              fc_fetchen_o,
  output logic                              periph_rst_n_o
);

  logic [periph_cfg_pkg::OFS_W-1:0]  ofs;
  logic                              wr_en;
  logic [periph_cfg_pkg::DATA_W-1:0] bootaddr_q;
  logic                              fetchen_q;
  logic                              soft_rst_q;  // one-cycle request

  assign ofs   = bus.paddr[periph_cfg_pkg::OFS_W-1:0];
  assign wr_en = bus.psel && bus.penable && bus.pwrite;  // commit at end of access

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bootaddr_q <= periph_cfg_pkg::BOOTADDR_RST;
      fetchen_q  <= 1'b0;
      soft_rst_q <= 1'b0;
    end else begin
      soft_rst_q <= wr_en && (ofs == periph_cfg_pkg::SOC_SOFTRST_OFS) && bus.pwdata[0];
      if (wr_en && (ofs == periph_cfg_pkg::SOC_BOOTADDR_OFS)) begin
        bootaddr_q <= bus.pwdata;
      end
      // pad override beats a bus write in the same cycle
      if (fc_fetch_en_valid_i) begin
        fetchen_q <= fc_fetch_en_i;
      end else if (wr_en && (ofs == periph_cfg_pkg::SOC_FETCHEN_OFS)) begin
        fetchen_q <= bus.pwdata[0];
      end
    end
  end

  // read side, combinational in the access phase
  always_comb begin
    case (ofs)
      periph_cfg_pkg::SOC_INFO_OFS:     bus.prdata = periph_cfg_pkg::INFO_WORD;
      periph_cfg_pkg::SOC_BOOTADDR_OFS: bus.prdata = bootaddr_q;
      periph_cfg_pkg::SOC_FETCHEN_OFS:  bus.prdata = {{(periph_cfg_pkg::DATA_W-1){1'b0}},
                                                      fetchen_q};
      default:                          bus.prdata = '0;  // softrst reads 0 too
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;

  assign fc_bootaddr_o = bootaddr_q;
  assign fc_fetchen_o  = fetchen_q;

  // peripheral reset, held with the system reset, pulsed by softrst
  assign periph_rst_n_o = rst_n_i && !soft_rst_q;

  // soft reset pulse never stretches past one cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !periph_rst_n_o |=> periph_rst_n_o);

endmodule

//--- hw/gpio_regs.sv
// GPIO block: pin direction and output registers, input synchroniser, rising-edge interrupt
`timescale 1ns/1ps

module gpio_regs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  apb_if.slave                              bus,
  input  logic [periph_cfg_pkg::N_GPIO-1:0] gpio_in_i,
  output logic [periph_cfg_pkg::N_GPIO-1:0] gpio_out_o,
  output logic [periph_cfg_pkg::N_GPIO-1:0] gpio_oe_o,
  output logic                              irq_o
);

  logic [periph_cfg_pkg::OFS_W-1:0]  ofs;
  logic                              wr_en;
  logic                              stat_rd;   // read of INTSTAT in access
  logic [periph_cfg_pkg::N_GPIO-1:0] dir_q;
  logic [periph_cfg_pkg::N_GPIO-1:0] out_q;
  logic [periph_cfg_pkg::N_GPIO-1:0] inten_q;
  logic [periph_cfg_pkg::N_GPIO-1:0] intstat_q;
  logic [periph_cfg_pkg::N_GPIO-1:0] sync1_q;
  logic [periph_cfg_pkg::N_GPIO-1:0] sync2_q;   // IN register view
  logic [periph_cfg_pkg::N_GPIO-1:0] prev_q;    // last synced value
  logic [periph_cfg_pkg::N_GPIO-1:0] rise;

  assign ofs     = bus.paddr[periph_cfg_pkg::OFS_W-1:0];
  assign wr_en   = bus.psel && bus.penable && bus.pwrite;
  assign stat_rd = bus.psel && bus.penable && !bus.pwrite &&
                   (ofs == periph_cfg_pkg::GPIO_INTSTAT_OFS);

  // two-flop synchroniser plus edge history
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in_i;
    sync2_q <= sync1_q;
    prev_q  <= sync2_q;
  end

  assign rise = sync2_q & ~prev_q & inten_q;  // only enabled pins

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q     <= '0;
      out_q     <= '0;
      inten_q   <= '0;
      intstat_q <= '0;
    end else begin
      if (wr_en && (ofs == periph_cfg_pkg::GPIO_DIR_OFS))   dir_q   <= bus.pwdata;
      if (wr_en && (ofs == periph_cfg_pkg::GPIO_OUT_OFS))   out_q   <= bus.pwdata;
      if (wr_en && (ofs == periph_cfg_pkg::GPIO_INTEN_OFS)) inten_q <= bus.pwdata;
      // clear what was returned, keep edges landing now
      intstat_q <= (stat_rd ? '0 : intstat_q) | rise;
    end
  end

  always_comb begin
    case (ofs)
      periph_cfg_pkg::GPIO_DIR_OFS:     bus.prdata = dir_q;
      periph_cfg_pkg::GPIO_IN_OFS:      bus.prdata = sync2_q;
      periph_cfg_pkg::GPIO_OUT_OFS:     bus.prdata = out_q;
      periph_cfg_pkg::GPIO_INTEN_OFS:   bus.prdata = inten_q;
      periph_cfg_pkg::GPIO_INTSTAT_OFS: bus.prdata = intstat_q;
      default:                          bus.prdata = '0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;
  assign irq_o      = |intstat_q;

  // irq only comes up after a detected edge on an enabled pin
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_o) |-> $past(|rise));

endmodule

//--- hw/timer_unit.sv
// timer unit: 32-bit counter on system clock or ref edges, compare irq, ref edge pulses
`timescale 1ns/1ps

module timer_unit (
  input  logic clk_i,
  input  logic rst_n_i,
  apb_if.slave bus,
  input  logic slow_clk_i,
  input  logic stoptimer_i,
  output logic irq_o,
  output logic ref_rise_o,
  output logic ref_fall_o
);

  logic [periph_cfg_pkg::OFS_W-1:0]  ofs;
  logic                              wr_en;
  logic                              cfg_wr;
  logic [2:0]                        ref_sync_q;  // 2 sync stages + history
  logic                              ref_rise_q;
  logic                              ref_fall_q;
  logic                              cfg_en_q;
  logic                              cfg_ref_q;
  logic [periph_cfg_pkg::DATA_W-1:0] count_q;
  logic [periph_cfg_pkg::DATA_W-1:0] cmp_q;
  logic                              tick;
  logic                              cmp_hit;
  logic                              irq_q;

  assign ofs    = bus.paddr[periph_cfg_pkg::OFS_W-1:0];
  assign wr_en  = bus.psel && bus.penable && bus.pwrite;
  assign cfg_wr = wr_en && (ofs == periph_cfg_pkg::TMR_CFG_OFS);

  ////////////////////////////////////////////////////////////
  // reference clock edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ref_sync_q <= '0;
      ref_rise_q <= 1'b0;
      ref_fall_q <= 1'b0;
    end else begin
      ref_sync_q <= {ref_sync_q[1:0], slow_clk_i};
      ref_rise_q <= ref_sync_q[1] && !ref_sync_q[2];
      ref_fall_q <= !ref_sync_q[1] && ref_sync_q[2];
    end
  end

  ////////////////////////////////////////////////////////////
  // counter and compare
  ////////////////////////////////////////////////////////////
  assign tick    = cfg_en_q && !stoptimer_i && (cfg_ref_q ? ref_rise_q : 1'b1);
  assign cmp_hit = (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_en_q  <= 1'b0;
      cfg_ref_q <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      irq_q     <= 1'b0;
    end else begin
      irq_q <= tick && cmp_hit;  // one pulse per wrap
      if (cfg_wr) begin
        cfg_en_q  <= bus.pwdata[periph_cfg_pkg::TMR_CFG_EN_BIT];
        cfg_ref_q <= bus.pwdata[periph_cfg_pkg::TMR_CFG_REF_BIT];
      end
      if (wr_en && (ofs == periph_cfg_pkg::TMR_CMP_OFS)) cmp_q <= bus.pwdata;
      if (cfg_wr && bus.pwdata[periph_cfg_pkg::TMR_CFG_CLR_BIT]) begin
        count_q <= '0;                               // clear wins over a tick
      end else if (tick) begin
        count_q <= cmp_hit ? '0 : count_q + 1'b1;    // wrap at compare
      end
    end
  end

  always_comb begin
    bus.prdata = '0;
    case (ofs)
      periph_cfg_pkg::TMR_CFG_OFS: begin
        bus.prdata[periph_cfg_pkg::TMR_CFG_EN_BIT]  = cfg_en_q;
        bus.prdata[periph_cfg_pkg::TMR_CFG_REF_BIT] = cfg_ref_q;  // clr bit stays 0
      end
      periph_cfg_pkg::TMR_COUNT_OFS: bus.prdata = count_q;
      periph_cfg_pkg::TMR_CMP_OFS:   bus.prdata = cmp_q;
      default: ;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;

  assign irq_o      = irq_q;
  assign ref_rise_o = ref_rise_q;
  assign ref_fall_o = ref_fall_q;

  // an edge pulse is a single cycle and is never followed directly by the other edge
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ref_rise_o || ref_fall_o) |=> !(ref_rise_o || ref_fall_o));

endmodule

//--- hw/soc_periph_top.sv
// peripheral subsystem top: APB decode, control, GPIO and timer blocks, event vector assembly
`timescale 1ns/1ps

module soc_periph_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                slow_clk_i,
  input  logic                                stoptimer_i,
  input  logic                                fc_fetch_en_valid_i,
  input  logic                                fc_fetch_en_i,
  input  logic [periph_cfg_pkg::ADDR_W-1:0]   apb_paddr_i,
  input  logic [periph_cfg_pkg::DATA_W-1:0]   apb_pwdata_i,
  input  logic                                apb_pwrite_i,
  input  logic                                apb_psel_i,
  input  logic                                apb_penable_i,
  output logic [periph_cfg_pkg::DATA_W-1:0]   apb_prdata_o,
  output logic                                apb_pready_o,
  output logic                                apb_pslverr_o,
  input  logic [periph_cfg_pkg::N_GPIO-1:0]   gpio_in_i,
  output logic [periph_cfg_pkg::N_GPIO-1:0]   gpio_out_o,
  output logic [periph_cfg_pkg::N_GPIO-1:0]   gpio_oe_o,
  output logic [periph_cfg_pkg::DATA_W-1:0]   fc_bootaddr_o,
  output logic                                fc_fetchen_o,
  output logic [periph_evt_pkg::N_FC_EVT-1:0] fc_events_o
);

  apb_if gpio_bus ();
  apb_if soc_ctrl_bus ();
  apb_if timer_bus ();

  logic periph_rst_n;  // system reset or softrst pulse
  logic gpio_irq;
  logic timer_irq;
  logic ref_rise;
  logic ref_fall;

  apb_periph_decoder apb_periph_decoder_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .paddr_i      (apb_paddr_i),
    .pwdata_i     (apb_pwdata_i),
    .pwrite_i     (apb_pwrite_i),
    .psel_i       (apb_psel_i),
    .penable_i    (apb_penable_i),
    .prdata_o     (apb_prdata_o),
    .pready_o     (apb_pready_o),
    .pslverr_o    (apb_pslverr_o),
    .gpio_bus     (gpio_bus),
    .soc_ctrl_bus (soc_ctrl_bus),
    .timer_bus    (timer_bus)
  );

  // control block stays on the system reset
  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .bus                 (soc_ctrl_bus),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o),
    .periph_rst_n_o      (periph_rst_n)
  );

  gpio_regs gpio_regs_i (
    .clk_i      (clk_i),
    .rst_n_i    (periph_rst_n),
    .bus        (gpio_bus),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (gpio_irq)
  );

  timer_unit timer_unit_i (
    .clk_i       (clk_i),
    .rst_n_i     (periph_rst_n),
    .bus         (timer_bus),
    .slow_clk_i  (slow_clk_i),
    .stoptimer_i (stoptimer_i),
    .irq_o       (timer_irq),
    .ref_rise_o  (ref_rise),
    .ref_fall_o  (ref_fall)
  );

  ////////////////////////////////////////////////////////////
  // fc event vector
  ////////////////////////////////////////////////////////////
  always_comb begin
    fc_events_o = '0;  // unused slots tied low
    fc_events_o[periph_evt_pkg::EVT_TIMER_LO]  = timer_irq;
    fc_events_o[periph_evt_pkg::EVT_GPIO]      = gpio_irq;
    fc_events_o[periph_evt_pkg::EVT_TIMER_IRQ] = timer_irq;
    fc_events_o[periph_evt_pkg::EVT_REF_RISE]  = ref_rise;
    fc_events_o[periph_evt_pkg::EVT_REF_FALL]  = ref_fall;
  end

endmodule

//--- verif/tb_soc_periph.sv
// self-checking testbench for the peripheral subsystem, run through vlog.f with tb_soc_periph as top
`timescale 1ns/1ps

module tb_soc_periph;

  localparam int          CLK_PERIOD      = 40;      // ns
  localparam int          READY_TIMEOUT   = 16;
  localparam int          WATCHDOG_CYCLES = 20000;
  localparam logic [31:0] LFSR_SEED       = 32'h91f0_05f4;

  // address map, one 4 KiB window per slave
  localparam logic [31:0] A_GPIO_DIR   = 32'h0000_0000;
  localparam logic [31:0] A_GPIO_IN    = 32'h0000_0004;
  localparam logic [31:0] A_GPIO_OUT   = 32'h0000_0008;
  localparam logic [31:0] A_GPIO_INTEN = 32'h0000_000C;
  localparam logic [31:0] A_GPIO_STAT  = 32'h0000_0010;
  localparam logic [31:0] A_SOC_INFO   = 32'h0000_1000;
  localparam logic [31:0] A_SOC_BOOT   = 32'h0000_1004;
  localparam logic [31:0] A_SOC_FETCH  = 32'h0000_1008;
  localparam logic [31:0] A_SOC_SRST   = 32'h0000_100C;
  localparam logic [31:0] A_TMR_CFG    = 32'h0000_2000;
  localparam logic [31:0] A_TMR_CNT    = 32'h0000_2004;
  localparam logic [31:0] A_TMR_CMP    = 32'h0000_2008;
  localparam logic [31:0] A_BAD_SLOT   = 32'h0000_3004;  // slot 3, unmapped

  localparam logic [31:0] BOOTADDR_RST = 32'h1C00_8080;
  localparam logic [31:0] INFO_WORD    = 32'h0001_0004;

  // event vector slots
  localparam int EV_TIMER_LO = 7;
  localparam int EV_GPIO     = 11;
  localparam int EV_TIMER    = 16;
  localparam int EV_RISE     = 18;
  localparam int EV_FALL     = 19;

  logic        clk_i;
  logic        rst_n_i;
  logic        slow_clk_i;
  logic        stoptimer_i;
  logic        fc_fetch_en_valid_i;
  logic        fc_fetch_en_i;
  logic [31:0] apb_paddr_i;
  logic [31:0] apb_pwdata_i;
  logic        apb_pwrite_i;
  logic        apb_psel_i;
  logic        apb_penable_i;
  logic [31:0] apb_prdata_o;
  logic        apb_pready_o;
  logic        apb_pslverr_o;
  logic [31:0] gpio_in_i;
  logic [31:0] gpio_out_o;
  logic [31:0] gpio_oe_o;
  logic [31:0] fc_bootaddr_o;
  logic        fc_fetchen_o;
  logic [31:0] fc_events_o;

  logic [31:0] lfsr_q;
  int          err_cnt;
  int          pass_cnt;
  int          test_errs;
  string       test_name;

  soc_periph_top soc_periph_top_i (.*);

  ////////////////////////////////////////////////////////////
  // clock, slow reference clock, watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  initial begin
    slow_clk_i = 1'b0;
    forever begin
      repeat (5) @(negedge clk_i);  // ref period is 10 clocks
      slow_clk_i = ~slow_clk_i;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  // galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[0];
    s  = s >> 1;
    if (fb) s = s ^ 32'h8020_0003;
    return s;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error %s/%s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
      test_errs++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    err_cnt++;
    test_errs++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    $display("%s finished, %0d errors", test_name, test_errs);
  endtask

  // entered and left on a falling edge, setup then access phase
  task automatic bus_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int waited;
    apb_paddr_i   = addr;
    apb_pwdata_i  = wdata;
    apb_pwrite_i  = wr;
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    @(negedge clk_i);
    apb_penable_i = 1'b1;
    waited = 0;
    #(CLK_PERIOD/4);                 // sample mid low phase
    while (!apb_pready_o && waited < READY_TIMEOUT) begin
      @(negedge clk_i);
      #(CLK_PERIOD/4);
      waited++;
    end
    if (!apb_pready_o) note_failure($sformatf("no pready for the access to %h", addr));
    rdata = apb_prdata_o;
    err   = apb_pslverr_o;
    @(negedge clk_i);                // write committed at the edge before this
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_transfer(1'b1, addr, data, rd, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  // polls one event bit on falling edges
  task automatic wait_event(input int bit_idx, input int limit, output int cycles);
    cycles = 0;
    while (!fc_events_o[bit_idx] && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!fc_events_o[bit_idx]) begin
      note_failure($sformatf("event bit %0d did not rise within %0d cycles", bit_idx, limit));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic        err;
    logic [31:0] val;
    logic [31:0] cmp;
    logic [31:0] exp_boot;     // reference model of the register contents
    logic        exp_fetchen;
    logic [31:0] exp_out;
    logic [31:0] exp_dir;
    logic [31:0] exp_inten;
    int          cycles;
    int          rises;
    int          last_edge;
    int          alt_errs;

    lfsr_q              = LFSR_SEED;
    err_cnt             = 0;
    pass_cnt            = 0;
    rst_n_i             = 1'b0;
    stoptimer_i         = 1'b0;
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    apb_paddr_i         = '0;
    apb_pwdata_i        = '0;
    apb_pwrite_i        = 1'b0;
    apb_psel_i          = 1'b0;
    apb_penable_i       = 1'b0;
    gpio_in_i           = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    start_test("reset_values");
    exp_boot    = BOOTADDR_RST;
    exp_fetchen = 1'b0;
    check_value("fc_bootaddr_o", exp_boot, fc_bootaddr_o);
    check_value("fc_fetchen_o", exp_fetchen, fc_fetchen_o);
    check_value("gpio_out_o", 0, gpio_out_o);
    check_value("gpio_oe_o", 0, gpio_oe_o);
    check_value("fc_events_o", 0, fc_events_o);
    apb_read(A_SOC_INFO, rd);
    check_value("info", INFO_WORD, rd);
    end_test();

    start_test("soc_ctrl");
    repeat (4) begin
      exp_boot = rand_bits(32);
      apb_write(A_SOC_BOOT, exp_boot);
      check_value("fc_bootaddr_o", exp_boot, fc_bootaddr_o);
      apb_read(A_SOC_BOOT, rd);
      check_value("bootaddr readback", exp_boot, rd);
    end
    exp_fetchen = 1'b1;
    apb_write(A_SOC_FETCH, 32'h1);
    check_value("fetchen by write", exp_fetchen, fc_fetchen_o);
    fc_fetch_en_valid_i = 1'b1;      // override pulse alone
    fc_fetch_en_i       = 1'b0;
    @(negedge clk_i);
    fc_fetch_en_valid_i = 1'b0;
    exp_fetchen = 1'b0;
    check_value("fetchen by override", exp_fetchen, fc_fetchen_o);
    fork
      apb_write(A_SOC_FETCH, 32'h1);
      begin
        @(negedge clk_i);            // lands in the write's access phase
        fc_fetch_en_valid_i = 1'b1;
        fc_fetch_en_i       = 1'b0;
        @(negedge clk_i);
        fc_fetch_en_valid_i = 1'b0;
      end
    join
    check_value("override beats write", exp_fetchen, fc_fetchen_o);
    apb_read(A_SOC_FETCH, rd);
    check_value("fetchen readback", exp_fetchen, rd);
    end_test();

    start_test("gpio");
    exp_out = rand_bits(32);
    exp_dir = rand_bits(32);
    apb_write(A_GPIO_OUT, exp_out);
    apb_write(A_GPIO_DIR, exp_dir);
    check_value("gpio_out_o", exp_out, gpio_out_o);
    check_value("gpio_oe_o", exp_dir, gpio_oe_o);
    apb_read(A_GPIO_OUT, rd);
    check_value("out readback", exp_out, rd);
    apb_read(A_GPIO_DIR, rd);
    check_value("dir readback", exp_dir, rd);
    repeat (4) begin
      val       = rand_bits(32);
      gpio_in_i = val;
      repeat (2) @(negedge clk_i);   // synchroniser depth
      apb_read(A_GPIO_IN, rd);
      check_value("in readback", val, rd);
    end
    gpio_in_i = '0;
    repeat (4) @(negedge clk_i);     // let edge history settle low
    exp_inten = rand_bits(32) | 32'h1;
    apb_write(A_GPIO_INTEN, exp_inten);
    val       = rand_bits(32) | 32'h1;
    gpio_in_i = val;
    wait_event(EV_GPIO, 20, cycles);
    check_value("irq latency", 3, cycles);
    apb_read(A_GPIO_STAT, rd);
    check_value("intstat", val & exp_inten, rd);
    check_value("gpio event after clear", 0, fc_events_o[EV_GPIO]);
    apb_read(A_GPIO_STAT, rd);
    check_value("intstat after clear", 0, rd);
    end_test();

    start_test("timer_clock");
    cmp = 2 + rand_bits(3);
    apb_write(A_TMR_CMP, cmp);
    apb_write(A_TMR_CFG, 32'h5);     // en + clr
    wait_event(EV_TIMER_LO, 64, cycles);
    check_value("irq mirror", 1, fc_events_o[EV_TIMER]);
    @(negedge clk_i);
    wait_event(EV_TIMER_LO, 64, cycles);
    check_value("irq period", cmp + 1, cycles + 1);
    apb_read(A_TMR_CNT, rd);
    check_value("count small after wrap", 1, rd <= 2);
    apb_write(A_TMR_CFG, 32'h0);
    end_test();

    start_test("timer_ref");
    cmp = 1 + rand_bits(2);
    apb_write(A_TMR_CMP, cmp);
    apb_write(A_TMR_CFG, 32'h7);     // en + ref + clr
    rises     = 0;
    last_edge = -1;
    alt_errs  = 0;
    cycles    = 0;
    while (!fc_events_o[EV_TIMER_LO] && cycles < 200) begin
      if (fc_events_o[EV_RISE] && fc_events_o[EV_FALL]) alt_errs++;
      if (fc_events_o[EV_RISE]) begin
        if (last_edge == 1) alt_errs++;
        last_edge = 1;
        rises++;
      end
      if (fc_events_o[EV_FALL]) begin
        if (last_edge == 0) alt_errs++;
        last_edge = 0;
      end
      @(negedge clk_i);
      cycles++;
    end
    if (!fc_events_o[EV_TIMER_LO]) note_failure("no timer irq in ref mode within 200 cycles");
    check_value("ref rises before irq", cmp + 1, rises);
    check_value("ref edges alternate", 0, alt_errs);
    apb_write(A_TMR_CFG, 32'h0);
    end_test();

    start_test("stoptimer");
    apb_write(A_TMR_CMP, 32'hFFFF_FFFF);
    apb_write(A_TMR_CFG, 32'h5);
    repeat (3) @(negedge clk_i);     // three ticks since the clear
    stoptimer_i = 1'b1;
    apb_read(A_TMR_CNT, rd);
    check_value("count at stop", 3, rd);
    repeat (5) @(negedge clk_i);
    apb_read(A_TMR_CNT, rd);
    check_value("count held", 3, rd);
    stoptimer_i = 1'b0;
    apb_read(A_TMR_CNT, rd);
    check_value("count resumed", 4, rd);
    end_test();

    start_test("unmapped_slot");
    bus_transfer(1'b0, A_BAD_SLOT, '0, rd, err);
    check_value("read pslverr", 1, err);
    check_value("read data", 0, rd);
    bus_transfer(1'b1, A_BAD_SLOT, rand_bits(32), rd, err);
    check_value("write pslverr", 1, err);
    bus_transfer(1'b0, A_SOC_INFO, '0, rd, err);
    check_value("mapped pslverr", 0, err);
    end_test();

    start_test("soft_reset");
    exp_out   = rand_bits(32) | 32'h1;
    exp_dir   = rand_bits(32) | 32'h1;
    exp_inten = rand_bits(32) | 32'h1;
    apb_write(A_GPIO_OUT, exp_out);
    apb_write(A_GPIO_DIR, exp_dir);
    apb_write(A_GPIO_INTEN, exp_inten);
    apb_write(A_TMR_CMP, rand_bits(32) | 32'h1);
    apb_write(A_TMR_CFG, 32'h1);
    exp_boot    = rand_bits(32);
    exp_fetchen = 1'b1;
    apb_write(A_SOC_BOOT, exp_boot);
    apb_write(A_SOC_FETCH, 32'h1);
    apb_write(A_SOC_SRST, 32'h1);
    @(negedge clk_i);                // peripheral reset taken at the edge before
    exp_out   = '0;
    exp_dir   = '0;
    exp_inten = '0;
    check_value("gpio_out_o", exp_out, gpio_out_o);
    check_value("gpio_oe_o", exp_dir, gpio_oe_o);
    apb_read(A_GPIO_OUT, rd);
    check_value("out", exp_out, rd);
    apb_read(A_GPIO_DIR, rd);
    check_value("dir", exp_dir, rd);
    apb_read(A_GPIO_INTEN, rd);
    check_value("inten", exp_inten, rd);
    apb_read(A_TMR_CFG, rd);
    check_value("timer cfg", 0, rd);
    apb_read(A_TMR_CMP, rd);
    check_value("timer cmp", 0, rd);
    apb_read(A_TMR_CNT, rd);
    check_value("timer count", 0, rd);
    check_value("fc_bootaddr_o kept", exp_boot, fc_bootaddr_o);
    check_value("fc_fetchen_o kept", exp_fetchen, fc_fetchen_o);
    end_test();

    $display("checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/periph_cfg_pkg.sv
hw/periph_evt_pkg.sv
hw/apb_if.sv
hw/apb_periph_decoder.sv
hw/soc_ctrl_regs.sv
hw/gpio_regs.sv
hw/timer_unit.sv
hw/soc_periph_top.sv
verif/tb_soc_periph.sv

//--- Bender.yml
package:
  name: soc_periph

sources:
  - hw/periph_cfg_pkg.sv
  - hw/periph_evt_pkg.sv
  - hw/apb_if.sv
  - hw/apb_periph_decoder.sv
  - hw/soc_ctrl_regs.sv
  - hw/gpio_regs.sv
  - hw/timer_unit.sv
  - hw/soc_periph_top.sv
  - target: simulation
    files:
      - verif/tb_soc_periph.sv
